/* Makefile */
VERILATOR ?= verilator
TOP       ?= spmm_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= -Wno-fatal
PASS_TEXT ?= No errors

.PHONY: sim clean

# Build and run, then fail unless the pass line appears in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* common/spmm_pkg.sv */
package spmm_pkg;

    // Matrix size, also the nonzero capacity of one CSR matrix
    localparam int N = 4;
    localparam int W = 8;

    // Rows carried by one RHS or output beat
    localparam int ROWS_PER_BEAT = 2;
    localparam int NUM_BEATS = N / ROWS_PER_BEAT;

    localparam int IDX_W = $clog2(N);
    // One extra bit so an end pointer can hold N
    localparam int PTR_W = IDX_W + 1;
    localparam int BEAT_W = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1;

    typedef logic [W-1:0] elem_t;
    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [BEAT_W-1:0] beat_idx_t;

    // Sparse LHS in CSR form, row_ptr holds end pointers
    typedef struct packed {
        ptr_t [N-1:0] row_ptr;
        idx_t [N-1:0] col;
        elem_t [N-1:0] val;
    } csr_t;

    // Indexed as [row][column]
    typedef elem_t [ROWS_PER_BEAT-1:0][N-1:0] row_beat_t;

    typedef elem_t [N-1:0] column_t;

    // Column-major, matrix[col][row]
    typedef column_t [N-1:0] matrix_t;

    // Per nonzero position: owning row and whether it lies below nnz
    typedef struct packed {
        idx_t [N-1:0] row;
        logic [N-1:0] live;
    } nz_tag_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_RHS,
        READY
    } ctrl_state_t;

endpackage

/* rtl/csr_decoder.sv */
module csr_decoder import spmm_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  logic           lhs_accept,
    input  ptr_t [N-1:0]   row_ptr,
    output nz_tag_t        tags
);

    nz_tag_t tags_next;

    // Row of nonzero k is the number of end pointers at or below k
    always_comb begin : decode
        ptr_t below;
        tags_next = '0;
        for (int k = 0; k < N; k++) begin
            below = '0;
            for (int r = 0; r < N; r++) begin
                if (row_ptr[r] <= ptr_t'(k)) begin
                    below = below + 1'b1;
                end
            end
            // Only truncates for dead positions, where the row is ignored
            tags_next.row[k] = idx_t'(below);
            // Last end pointer is nnz
            tags_next.live[k] = ptr_t'(k) < row_ptr[N-1];
        end
    end

    // Held until the next accept so the sum stage sees the right tags
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tags <= '0;
        end else if (lhs_accept) begin
            tags <= tags_next;
        end
    end

endmodule

/* rtl/out_serializer.sv */
module out_serializer import spmm_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      sum_valid,
    input  matrix_t   sums,
    output logic      out_valid,
    output row_beat_t out_beat,
    output beat_idx_t out_beat_idx
);

    matrix_t c_buf;
    logic    last_beat;

    assign last_beat = (out_beat_idx == beat_idx_t'(NUM_BEATS - 1));

    always_ff @(posedge clock) begin
        if (sum_valid) begin
            c_buf <= sums;
        end
    end

    // A capture on the last beat restarts at beat 0 with no gap
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_beat_idx <= '0;
        end else if (sum_valid) begin
            out_valid <= 1'b1;
            out_beat_idx <= '0;
        end else if (out_valid) begin
            if (last_beat) begin
                out_valid <= 1'b0;
                out_beat_idx <= '0;
            end else begin
                out_beat_idx <= out_beat_idx + 1'b1;
            end
        end
    end

    // Beat b carries rows 2b and 2b+1, turned back to row-major
    always_comb begin
        for (int r = 0; r < ROWS_PER_BEAT; r++) begin
            for (int c = 0; c < N; c++) begin
                out_beat[r][c] = c_buf[c][idx_t'(int'(out_beat_idx) * ROWS_PER_BEAT + r)];
            end
        end
    end

endmodule

/* rtl/rhs_loader.sv */
module rhs_loader import spmm_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      rhs_accept,
    input  row_beat_t rhs_beat,
    output logic      load_done,
    output matrix_t   rhs_matrix
);

    beat_idx_t beat_cnt;
    logic      last_beat;

    // Column-major copy of B, one column per PE
    matrix_t rhs_buf;

    assign last_beat = (beat_cnt == beat_idx_t'(NUM_BEATS - 1));

    // Pulses on the edge that takes the final beat
    assign load_done = rhs_accept && last_beat;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            beat_cnt <= '0;
        end else if (rhs_accept) begin
            // Wrap so a later reload starts again at rows 0..1
            if (last_beat) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Beat b lands in rows 2b and 2b+1 of every column
    always_ff @(posedge clock) begin
        if (rhs_accept) begin
            for (int r = 0; r < ROWS_PER_BEAT; r++) begin
                for (int c = 0; c < N; c++) begin
                    rhs_buf[c][idx_t'(int'(beat_cnt) * ROWS_PER_BEAT + r)] <= rhs_beat[r][c];
                end
            end
        end
    end

    assign rhs_matrix = rhs_buf;

endmodule

/* rtl/spmm_ctrl.sv */
module spmm_ctrl import spmm_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic rhs_valid,
    input  logic lhs_valid,
    input  logic load_done,
    output logic rhs_ready,
    output logic lhs_ready,
    output logic rhs_accept,
    output logic lhs_accept,
    output logic sum_valid
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        cooldown;

    // Bit 0 marks the product stage, bit 1 the sum stage
    logic [1:0]  pipe_valid;

    // B can always be (re)loaded
    assign rhs_ready = 1'b1;
    assign rhs_accept = rhs_valid && rhs_ready;

    // RHS has priority, so LHS is not ready while an RHS beat is offered
    assign lhs_ready = (state == READY) && !cooldown && !rhs_valid;
    assign lhs_accept = lhs_valid && lhs_ready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE, LOAD_RHS, READY: begin
                // Any beat starts or continues a load
                if (rhs_accept) begin
                    if (load_done) begin
                        state_next = READY;
                    end else begin
                        state_next = LOAD_RHS;
                    end
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            cooldown <= 1'b0;
            pipe_valid <= '0;
        end else begin
            state <= state_next;
            // One idle cycle after each accept
            cooldown <= lhs_accept;
            pipe_valid <= {pipe_valid[0], lhs_accept};
        end
    end

    assign sum_valid = pipe_valid[1];

endmodule

/* rtl/spmm_pe.sv */
module spmm_pe import spmm_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  logic          lhs_accept,
    input  idx_t [N-1:0]  col_idx,
    input  elem_t [N-1:0] val,
    input  column_t       rhs_col,
    input  nz_tag_t       tags,
    output column_t       col_sums
);

    elem_t [N-1:0] prod;
    column_t       row_sum;
    logic          prod_valid;

    // Multipliers sample B only here, so a reload cannot disturb this matrix
    always_ff @(posedge clock) begin
        if (lhs_accept) begin
            for (int k = 0; k < N; k++) begin
                prod[k] <= elem_t'(val[k] * rhs_col[col_idx[k]]);
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= lhs_accept;
        end
    end

    // Segmented sum over the products, one segment per row
    always_comb begin
        row_sum = '0;
        for (int r = 0; r < N; r++) begin
            for (int k = 0; k < N; k++) begin
                if (tags.live[k] && (tags.row[k] == idx_t'(r))) begin
                    row_sum[r] = row_sum[r] + prod[k];
                end
            end
        end
    end

    // Empty rows fall out as zero
    always_ff @(posedge clock) begin
        if (prod_valid) begin
            col_sums <= row_sum;
        end
    end

endmodule

/* rtl/spmm_top.sv */
module spmm_top import spmm_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      rhs_valid,
    input  row_beat_t rhs_beat,
    input  logic      lhs_valid,
    input  csr_t      lhs,
    output logic      rhs_ready,
    output logic      lhs_ready,
    output logic      out_valid,
    output row_beat_t out_beat,
    output beat_idx_t out_beat_idx
);

    logic    rhs_accept;
    logic    lhs_accept;
    logic    load_done;
    logic    sum_valid;
    matrix_t rhs_matrix;
    matrix_t pe_sums;
    nz_tag_t tags;

    spmm_ctrl u_ctrl (
        .clock      (clock),
        .reset      (reset),
        .rhs_valid  (rhs_valid),
        .lhs_valid  (lhs_valid),
        .load_done  (load_done),
        .rhs_ready  (rhs_ready),
        .lhs_ready  (lhs_ready),
        .rhs_accept (rhs_accept),
        .lhs_accept (lhs_accept),
        .sum_valid  (sum_valid)
    );

    rhs_loader u_rhs_loader (
        .clock      (clock),
        .reset      (reset),
        .rhs_accept (rhs_accept),
        .rhs_beat   (rhs_beat),
        .load_done  (load_done),
        .rhs_matrix (rhs_matrix)
    );

    // Row split is the same for every column, so it is decoded once
    csr_decoder u_csr_decoder (
        .clock      (clock),
        .reset      (reset),
        .lhs_accept (lhs_accept),
        .row_ptr    (lhs.row_ptr),
        .tags       (tags)
    );

    // One PE per column of B and C
    for (genvar i = 0; i < N; i++) begin : g_pe
        spmm_pe u_pe (
            .clock      (clock),
            .reset      (reset),
            .lhs_accept (lhs_accept),
            .col_idx    (lhs.col),
            .val        (lhs.val),
            .rhs_col    (rhs_matrix[i]),
            .tags       (tags),
            .col_sums   (pe_sums[i])
        );
    end

    out_serializer u_out_serializer (
        .clock        (clock),
        .reset        (reset),
        .sum_valid    (sum_valid),
        .sums         (pe_sums),
        .out_valid    (out_valid),
        .out_beat     (out_beat),
        .out_beat_idx (out_beat_idx)
    );

endmodule

/* sim.f */
common/spmm_pkg.sv
rtl/rhs_loader.sv
rtl/csr_decoder.sv
rtl/spmm_pe.sv
rtl/spmm_ctrl.sv
rtl/out_serializer.sv
rtl/spmm_top.sv
testbench/spmm_tb.sv

/* testbench/spmm_tb.sv */
module spmm_tb import spmm_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 50;
    localparam int NUM_RANDOM = 40;

    logic      clock;
    logic      reset;
    logic      rhs_valid;
    row_beat_t rhs_beat;
    logic      lhs_valid;
    csr_t      lhs;
    logic      rhs_ready;
    logic      lhs_ready;
    logic      out_valid;
    row_beat_t out_beat;
    beat_idx_t out_beat_idx;

    logic [15:0] lfsr;
    int          edge_count = 0;
    int          error_count;
    int          check_count;
    int          rhs_beat_model;
    string       test_name;

    // Reference copy of B indexed [row][column]
    elem_t b_model [N][N];

    // Expected output beats in arrival order
    row_beat_t exp_beat_q[$];
    beat_idx_t exp_idx_q[$];
    int        exp_edge_q[$];
    string     exp_name_q[$];

    spmm_top UUT (
        .clock        (clock),
        .reset        (reset),
        .rhs_valid    (rhs_valid),
        .rhs_beat     (rhs_beat),
        .lhs_valid    (lhs_valid),
        .lhs          (lhs),
        .rhs_ready    (rhs_ready),
        .lhs_ready    (lhs_ready),
        .out_valid    (out_valid),
        .out_beat     (out_beat),
        .out_beat_idx (out_beat_idx)
    );

    always #4 clock = ~clock;

    always @(posedge clock) edge_count <= edge_count + 1;

    task automatic fail_value(input string name, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
        $display("FAIL %s %s: expected %h, actual %h", name, what, expected, actual);
        error_count++;
    endtask

    task automatic report_error(input string msg);
        $display("Error in %s: %s", test_name, msg);
        error_count++;
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout in %s while waiting for %s", test_name, what);
        error_count++;
        finish_run();
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic row_beat_t random_beat();
        row_beat_t beat;
        for (int r = 0; r < ROWS_PER_BEAT; r++) begin
            for (int c = 0; c < N; c++) begin
                beat[r][c] = elem_t'(rand_bits(W));
            end
        end
        return beat;
    endfunction

    // Kind 0 is an empty matrix, kind 1 puts every nonzero in one row
    function automatic csr_t random_csr(input int kind);
        csr_t m;
        int   nnz;
        int   prev;
        int   row;
        for (int k = 0; k < N; k++) begin
            m.col[k] = idx_t'(rand_bits(IDX_W));
            m.val[k] = elem_t'(rand_bits(W));
        end
        if (kind == 1) begin
            row = rand_bits(IDX_W);
            for (int r = 0; r < N; r++) begin
                m.row_ptr[r] = (r < row) ? ptr_t'(0) : ptr_t'(N);
            end
        end else begin
            nnz = (kind == 0) ? 0 : rand_bits(3) % (N + 1);
            prev = 0;
            for (int r = 0; r < N - 1; r++) begin
                prev = prev + rand_bits(3) % (nnz - prev + 1);
                m.row_ptr[r] = ptr_t'(prev);
            end
            m.row_ptr[N-1] = ptr_t'(nnz);
        end
        return m;
    endfunction

    // Row r owns nonzeros from the previous end pointer up to its own
    task automatic push_expected(input csr_t m, input int acc_edge, input string name);
        elem_t     c_model [N][N];
        int        start;
        row_beat_t beat;
        for (int r = 0; r < N; r++) begin
            for (int j = 0; j < N; j++) begin
                c_model[r][j] = '0;
            end
        end
        start = 0;
        for (int r = 0; r < N; r++) begin
            for (int k = start; k < int'(m.row_ptr[r]); k++) begin
                for (int j = 0; j < N; j++) begin
                    c_model[r][j] = elem_t'(int'(c_model[r][j])
                        + int'(m.val[k]) * int'(b_model[m.col[k]][j]));
                end
            end
            start = int'(m.row_ptr[r]);
        end
        for (int b = 0; b < NUM_BEATS; b++) begin
            for (int r = 0; r < ROWS_PER_BEAT; r++) begin
                for (int j = 0; j < N; j++) begin
                    beat[r][j] = c_model[b * ROWS_PER_BEAT + r][j];
                end
            end
            exp_beat_q.push_back(beat);
            exp_idx_q.push_back(beat_idx_t'(b));
            exp_edge_q.push_back(acc_edge + 3 + b);
            exp_name_q.push_back(name);
        end
    endtask

    task automatic send_rhs(input row_beat_t beat, input bit with_lhs, input csr_t other);
        int waited;
        @(negedge clock);
        rhs_beat = beat;
        rhs_valid = 1'b1;
        lhs = other;
        lhs_valid = with_lhs;
        #1;
        waited = 0;
        while (!rhs_ready && waited < TIMEOUT) begin
            @(negedge clock);
            #1;
            waited++;
        end
        if (!rhs_ready) abort_on_timeout("rhs_ready");
        check_count++;
        if (with_lhs && lhs_ready !== 1'b0) report_error("lhs_ready high with an RHS beat offered");
        for (int r = 0; r < ROWS_PER_BEAT; r++) begin
            for (int c = 0; c < N; c++) begin
                b_model[rhs_beat_model * ROWS_PER_BEAT + r][c] = beat[r][c];
            end
        end
        rhs_beat_model = (rhs_beat_model + 1) % NUM_BEATS;
        @(negedge clock);
        rhs_valid = 1'b0;
        lhs_valid = 1'b0;
    endtask

    task automatic load_rhs_matrix(input bit with_lhs);
        for (int b = 0; b < NUM_BEATS; b++) begin
            send_rhs(random_beat(), with_lhs, random_csr(2));
        end
        #1;
        check_count++;
        if (lhs_ready !== 1'b1) report_error("lhs_ready not high after the last RHS beat");
    endtask

    // With hold set, lhs_valid stays high for the next matrix
    task automatic offer_lhs(input csr_t m, input bit hold, output int acc_edge);
        int waited;
        @(negedge clock);
        lhs = m;
        lhs_valid = 1'b1;
        rhs_valid = 1'b0;
        #1;
        waited = 0;
        while (!lhs_ready && waited < TIMEOUT) begin
            @(negedge clock);
            #1;
            waited++;
        end
        if (!lhs_ready) abort_on_timeout("lhs_ready");
        acc_edge = edge_count + 1;
        push_expected(m, acc_edge, test_name);
        if (!hold) begin
            @(negedge clock);
            lhs_valid = 1'b0;
        end
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_beat_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        if (exp_beat_q.size() != 0) abort_on_timeout("output beats");
        // Idle cycles let the monitor catch stray beats
        repeat (4) @(negedge clock);
    endtask

    // Output monitor checks every beat and the edge it is taken on
    always @(negedge clock) begin
        if (!reset && out_valid) begin
            if (exp_beat_q.size() == 0) begin
                $display("Error: unexpected output beat %0d at edge %0d", out_beat_idx,
                         edge_count);
                error_count++;
            end else begin
                check_count += 3;
                if (out_beat_idx !== exp_idx_q[0])
                    fail_value(exp_name_q[0], "out_beat_idx", exp_idx_q[0], out_beat_idx);
                if (out_beat !== exp_beat_q[0])
                    fail_value(exp_name_q[0], "out_beat", exp_beat_q[0], out_beat);
                // Beat is taken on the rising edge that follows
                if (edge_count + 1 != exp_edge_q[0])
                    fail_value(exp_name_q[0], "beat edge", exp_edge_q[0], edge_count + 1);
                void'(exp_beat_q.pop_front());
                void'(exp_idx_q.pop_front());
                void'(exp_edge_q.pop_front());
                void'(exp_name_q.pop_front());
            end
        end
    end

    initial begin
        int acc;
        int prev_acc;
        clock = 1'b0;
        reset = 1'b1;
        rhs_valid = 1'b0;
        rhs_beat = '0;
        lhs_valid = 1'b0;
        lhs = '0;
        lfsr = 16'd13;
        error_count = 0;
        check_count = 0;
        rhs_beat_model = 0;
        test_name = "reset";
        repeat (4) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_count += 3;
        if (out_valid !== 1'b0) report_error("out_valid high after reset");
        if (lhs_ready !== 1'b0) report_error("lhs_ready high after reset");
        if (rhs_ready !== 1'b1) report_error("rhs_ready low after reset");

        test_name = "rhs_load";
        send_rhs(random_beat(), 1'b0, '0);
        // Load is partial, so this LHS must not be taken
        lhs = random_csr(2);
        lhs_valid = 1'b1;
        #1;
        check_count++;
        if (lhs_ready !== 1'b0) report_error("lhs_ready high during a partial RHS load");
        send_rhs(random_beat(), 1'b0, '0);
        #1;
        check_count++;
        if (lhs_ready !== 1'b1) report_error("lhs_ready not high after the last RHS beat");
        drain_outputs();

        test_name = "random_products";
        for (int i = 0; i < NUM_RANDOM; i++) begin
            offer_lhs(random_csr((i % 10 < 2) ? i % 10 : 2), 1'b0, acc);
        end
        drain_outputs();

        test_name = "back_to_back";
        prev_acc = 0;
        for (int i = 0; i < 6; i++) begin
            offer_lhs(random_csr(2), i < 5, acc);
            check_count++;
            if (i > 0 && acc != prev_acc + 2)
                fail_value(test_name, "accept edge", prev_acc + 2, acc);
            prev_acc = acc;
        end
        drain_outputs();

        test_name = "rhs_reload";
        offer_lhs(random_csr(2), 1'b0, acc);
        // New B arrives while the matrix above is still in the pipeline
        load_rhs_matrix(1'b1);
        offer_lhs(random_csr(2), 1'b0, acc);
        offer_lhs(random_csr(1), 1'b0, acc);
        drain_outputs();

        finish_run();
    end

endmodule
